// File: Makefile
# Verilator build and run of the CORDIC testbench.

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, search $(LOG) for the pass message"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing -f build.f --top-module tb_cordic -Mdir obj_dir -o vsim
	./obj_dir/vsim | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: build.f
+incdir+src
src/cordic_pkg.sv
src/cordic_atan_rom.sv
src/cordic_sequencer.sv
src/cordic_datapath.sv
src/cordic_quadrant_fix.sv
src/cordic_top.sv
dv/cordic_checker.sv
dv/tb_cordic.sv

// File: dv/cordic_checker.sv
// ------------------------------
// CORDIC monitor: handshake timing, result tolerance and hold checks.
// ------------------------------
`timescale 1ns/100ps
`include "cordic_defs.svh"

module cordic_checker (
    input  logic                     clk,               // System clock.
    input  logic                     rst_n,             // Async reset, active low.
    input  logic                     beg_cordic,        // Start strobe seen by the DUT.
    input  logic                     ack_cordic,        // Acknowledge seen by the DUT.
    input  logic                     ready_cordic,      // DUT ready level.
    input  cordic_pkg::cordic_word_t data_output,       // DUT result.
    input  cordic_pkg::cordic_word_t exp_result,        // Expected word for this start.
    input  logic [15:0]              exp_tol,           // Allowed error in LSB.
    output int                       err_count,         // Failed checks.
    output int                       result_count       // Results compared.
);

    import cordic_pkg::*;

    typedef enum logic [1:0] {
        mon_idle,                                       // Engine free, ready low.
        mon_busy,                                       // Counting the latency.
        mon_wait                                        // Ready held until ack.
    } mon_state_t;

    mon_state_t   mon_state   = mon_idle;
    int           lat_cnt     = 0;                      // Edges since the start edge.
    int           err_cnt     = 0;
    int           result_cnt  = 0;
    int           tol_q       = 0;
    cordic_word_t exp_q       = '0;
    cordic_word_t held        = '0;                     // Result at the rise of ready.
    logic         seen_result = 1'b0;

    assign err_count    = err_cnt;
    assign result_count = result_cnt;

    // ------------------------------
    // Helpers
    // ------------------------------
    task automatic report_value(input string sig, input int got, input int expected);
        $display("CHECK FAILED time=%0t %s got %0d expected %0d", $time, sig, got, expected);
        err_cnt = err_cnt + 1;
    endtask

    function automatic bit within_tol(input int got, input int expv, input int tol);
        int diff;
        diff = got - expv;
        if (diff < 0)
        begin
            diff = -diff;
        end
        return diff <= tol;
    endfunction

    // ------------------------------
    // Monitor, sampled at the rising edge
    // ------------------------------
    always @(posedge clk)
    begin
        if (!rst_n)
        begin
            if (ready_cordic !== 1'b0)
            begin
                report_value("ready_cordic", int'(ready_cordic), 0);    // Low in reset.
            end
            mon_state <= mon_idle;
        end
        else
        begin
            case (mon_state)
                mon_idle:
                begin
                    if (ready_cordic !== 1'b0)
                    begin
                        report_value("ready_cordic", int'(ready_cordic), 0);
                    end
                    if (!seen_result && data_output !== '0)
                    begin
                        report_value("data_output", int'(data_output), 0);   // Reset value.
                    end
                    if (beg_cordic)
                    begin
                        exp_q     <= exp_result;        // Start is honoured here.
                        tol_q     <= int'(exp_tol);
                        lat_cnt   <= 0;
                        mon_state <= mon_busy;
                    end
                end
                mon_busy:
                begin
                    if (lat_cnt < `CORDIC_LATENCY)
                    begin
                        if (ready_cordic !== 1'b0)
                        begin
                            report_value("ready_cordic", int'(ready_cordic), 0);  // Too early.
                        end
                        lat_cnt <= lat_cnt + 1;
                    end
                    else
                    begin
                        if (ready_cordic !== 1'b1)
                        begin
                            report_value("ready_cordic", int'(ready_cordic), 1);  // Late.
                        end
                        else if (!within_tol(int'(data_output), int'(exp_q), tol_q))
                        begin
                            report_value("data_output", int'(data_output), int'(exp_q));
                        end
                        result_cnt  = result_cnt + 1;
                        held        <= data_output;
                        seen_result <= 1'b1;
                        mon_state   <= ack_cordic ? mon_idle : mon_wait;  // Ack may come at once.
                    end
                end
                default:
                begin
                    if (ready_cordic !== 1'b1)
                    begin
                        report_value("ready_cordic", int'(ready_cordic), 1);  // Dropped early.
                    end
                    if (data_output !== held)
                    begin
                        report_value("data_output", int'(data_output), int'(held));
                        held <= data_output;            // Report each change once.
                    end
                    if (ack_cordic)
                    begin
                        mon_state <= mon_idle;          // Starts are ignored until here.
                    end
                end
            endcase
        end
    end

endmodule

// File: dv/cordic_stim.txt
// op region angle expected tol, all hex; op 1 is sine, 0 is cosine
// angle and expected are Q1.14 words, tol is the allowed error in LSB
0 0 0000 4000 0010
0 0 2183 376D 0010
0 0 3244 2D41 0010
0 0 4305 2000 0010
0 0 4000 2294 0010
0 0 6000 0487 0010
0 0 CDBC 2D41 0010
0 0 6488 0000 0010
1 0 0000 0000 0010
1 0 2183 2000 0010
1 0 3244 2D41 0010
1 0 4305 376D 0010
1 0 4000 35DB 0010
1 0 6000 3FD7 0010
1 0 CDBC D2BF 0010
1 0 A000 C029 0010
1 0 6488 4000 0010
0 1 4305 E000 0010
0 2 2000 C7D6 0010
0 3 4000 2294 0010
1 1 3244 2D41 0010
1 2 4000 CA25 0010
1 3 2000 E151 0010
0 1 0000 C000 0010

// File: dv/tb_cordic.sv
// ------------------------------
// CORDIC testbench with file-driven cases, random ack delay and stray start pulses.
// ------------------------------
`timescale 1ns/100ps
`include "cordic_defs.svh"

module tb_cordic;

    import cordic_pkg::*;

    localparam int MAX_CASES  = 64;
    localparam int STIM_WORDS = MAX_CASES * 5;          // Five columns per case.

    logic         clk = 1'b0;
    logic         rst_n;
    logic         beg_cordic;
    logic         ack_cordic;
    logic         operation;
    region_t      shift_region;
    cordic_word_t data_in;
    logic         ready_cordic;
    cordic_word_t data_output;

    cordic_word_t exp_result;                           // To the checker.
    logic [15:0]  exp_tol;
    int           chk_errors;
    int           chk_results;

    logic [15:0]  stim_mem [0:STIM_WORDS-1];
    int           n_cases;
    int           tb_errors;
    int           timeout_limit = 1000;                 // Replaced once the file is read.
    int           cycle_cnt;

    always #4 clk = ~clk;                               // 8 ns period.

    cordic_top u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .beg_cordic   (beg_cordic),
        .ack_cordic   (ack_cordic),
        .operation    (operation),
        .shift_region (shift_region),
        .data_in      (data_in),
        .ready_cordic (ready_cordic),
        .data_output  (data_output)
    );

    cordic_checker u_checker (
        .clk          (clk),
        .rst_n        (rst_n),
        .beg_cordic   (beg_cordic),
        .ack_cordic   (ack_cordic),
        .ready_cordic (ready_cordic),
        .data_output  (data_output),
        .exp_result   (exp_result),
        .exp_tol      (exp_tol),
        .err_count    (chk_errors),
        .result_count (chk_results)
    );

    // ------------------------------
    // Stimulus helpers
    // ------------------------------
    task automatic load_cases;
        int i;
        for (i = 0; i < STIM_WORDS; i++)
        begin
            stim_mem[i] = 16'hFFFF;                     // Marks the end of the cases.
        end
        $readmemh("dv/cordic_stim.txt", stim_mem);
        n_cases = 0;
        while (n_cases < MAX_CASES && stim_mem[n_cases * 5] != 16'hFFFF)
        begin
            n_cases = n_cases + 1;
        end
    endtask

    // Entered and left on a falling edge.
    task automatic run_case(input int idx);
        int base;
        int delay;
        int i;
        base         = idx * 5;
        operation    = stim_mem[base][0];
        shift_region = stim_mem[base + 1][1:0];
        data_in      = stim_mem[base + 2];
        exp_result   = stim_mem[base + 3];
        exp_tol      = stim_mem[base + 4];
        beg_cordic   = 1'b1;
        @(negedge clk);
        beg_cordic   = 1'b0;
        if (idx % 3 == 1)
        begin
            repeat (20) @(negedge clk);
            operation    = ~operation;                  // Stray start with other inputs.
            shift_region = ~shift_region;
            data_in      = ~data_in;
            beg_cordic   = 1'b1;
            @(negedge clk);
            beg_cordic   = 1'b0;
        end
        while (!ready_cordic)
        begin
            @(negedge clk);                             // Watchdog bounds this wait.
        end
        delay = $urandom_range(30, 0);
        for (i = 0; i < delay; i++)
        begin
            beg_cordic = (i == 1) && (idx % 2 == 0);    // Start while ready is held.
            @(negedge clk);
        end
        beg_cordic = 1'b0;
        ack_cordic = 1'b1;
        @(negedge clk);
        ack_cordic = 1'b0;
    endtask

    // ------------------------------
    // Watchdog
    // ------------------------------
    initial
    begin
        cycle_cnt = 0;
        while (cycle_cnt < timeout_limit)
        begin
            @(posedge clk);
            cycle_cnt = cycle_cnt + 1;
        end
        $display("TIMEOUT: DUT did not finish all cases within %0d cycles", timeout_limit);
        $display("Simulation finished: FAIL");
        $finish;
    end

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial
    begin
        int idx;
        rst_n        = 1'b1;
        beg_cordic   = 1'b0;
        ack_cordic   = 1'b0;
        operation    = 1'b0;
        shift_region = '0;
        data_in      = '0;
        exp_result   = '0;
        exp_tol      = '0;
        tb_errors    = 0;
        void'($urandom(81712));                         // Seeds the ack delays.
        load_cases();
        timeout_limit = n_cases * (`CORDIC_LATENCY + 20) + 100;
        if (n_cases == 0)
        begin
            $display("ERROR: no cases were read from dv/cordic_stim.txt");
            tb_errors = tb_errors + 1;
        end
        #1 rst_n = 1'b0;                                // Async assert.
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (3) @(negedge clk);                      // Idle gap before the first start.
        for (idx = 0; idx < n_cases; idx++)
        begin
            run_case(idx);
        end
        repeat (5) @(negedge clk);
        if (chk_results != n_cases)
        begin
            $display("ERROR: %0d results were checked for %0d cases", chk_results, n_cases);
            tb_errors = tb_errors + 1;
        end
        $display("Errors: checker %0d, testbench %0d; results checked %0d of %0d",
                 chk_errors, tb_errors, chk_results, n_cases);
        if (chk_errors + tb_errors == 0)
        begin
            $display("Simulation finished: PASS");
        end
        else
        begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: src/cordic_atan_rom.sv
// ------------------------------
// Arctangent table, atan(2^-i) in Q1.14, addressed by the iteration counter.
// ------------------------------
`timescale 1ns/100ps
`include "cordic_defs.svh"

module cordic_atan_rom (
    input  cordic_pkg::iter_idx_t    iter,              // Current iteration.
    output cordic_pkg::cordic_word_t atan               // atan(2^-iter).
);

    import cordic_pkg::*;

    // Values are round(atan(2^-i) * 2^CORDIC_FRAC_W).
    localparam cordic_word_t atan_lut [`CORDIC_ITERS] = '{
        `CORDIC_WORD_W'(12868),                         // 0.785398 rad.
        `CORDIC_WORD_W'(7596),                          // 0.463648 rad.
        `CORDIC_WORD_W'(4014),                          // 0.244979 rad.
        `CORDIC_WORD_W'(2037),                          // 0.124355 rad.
        `CORDIC_WORD_W'(1023),                          // 0.062419 rad.
        `CORDIC_WORD_W'(512),                           // 0.031240 rad.
        `CORDIC_WORD_W'(256),                           // 0.015624 rad.
        `CORDIC_WORD_W'(128),                           // 0.007812 rad.
        `CORDIC_WORD_W'(64),                            // From here on atan(x) ~ x.
        `CORDIC_WORD_W'(32),
        `CORDIC_WORD_W'(16),
        `CORDIC_WORD_W'(8),
        `CORDIC_WORD_W'(4),
        `CORDIC_WORD_W'(2),
        `CORDIC_WORD_W'(1),
        `CORDIC_WORD_W'(0)                              // Below half an LSB.
    };

    // ------------------------------
    // Lookup
    // ------------------------------
    always_comb
    begin
        atan = atan_lut[iter];                          // Pure decode, no clock.
    end

endmodule

// File: src/cordic_datapath.sv
// ------------------------------
// CORDIC datapath: X/Y/Z registers, snapshots, shifters, one shared add/sub.
// ------------------------------
`timescale 1ns/100ps
`include "cordic_defs.svh"

module cordic_datapath (
    input  logic                     clk,               // System clock.
    input  logic                     rst_n,             // Async reset, active low.
    input  cordic_pkg::cordic_word_t data_in,           // Angle, radians.
    input  logic                     load_init,         // Idle, angle tracked.
    input  logic                     snap_en,           // Take the snapshot.
    input  logic                     slot_en,           // Adder result is written.
    input  cordic_pkg::var_slot_t    slot,              // Adder owner.
    input  cordic_pkg::iter_idx_t    iter,              // Shift amount.
    input  cordic_pkg::cordic_word_t atan,              // Table entry for Z.
    output cordic_pkg::cordic_word_t x_out,             // Final X, cosine.
    output cordic_pkg::cordic_word_t y_out              // Final Y, sine.
);

    import cordic_pkg::*;

    cordic_word_t z_init;                               // Latched angle.
    logic         init_sel;                             // Next snapshot takes initial values.
    cordic_word_t x_reg, y_reg, z_reg;                  // Iterated values.
    cordic_word_t x_snap, y_snap, z_snap;               // Held for one iteration.
    cordic_word_t x_sh, y_sh;                           // Shifted snapshots.
    cordic_word_t operand_a, operand_b;                 // Shared adder inputs.
    cordic_word_t sum;                                  // Shared adder output.
    logic         z_neg;                                // Rotation direction.
    logic         sub;                                  // 1 subtracts.

    // ------------------------------
    // Initial values
    // ------------------------------
    always_ff @(posedge clk)
    begin
        if (load_init)
        begin
            z_init <= data_in;                          // Last idle edge is the start edge.
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            init_sel <= 1'b0;
        end
        else if (load_init)
        begin
            init_sel <= 1'b1;                           // Armed until the first snapshot.
        end
        else if (snap_en)
        begin
            init_sel <= 1'b0;
        end
    end

    // Start-of-iteration mux into the snapshot line.
    always_ff @(posedge clk)
    begin
        if (snap_en)
        begin
            x_snap <= init_sel ? `CORDIC_X0 : x_reg;
            y_snap <= init_sel ? '0 : y_reg;
            z_snap <= init_sel ? z_init : z_reg;
        end
    end

    // ------------------------------
    // Shifters and shared adder
    // ------------------------------
    assign x_sh  = x_snap >>> iter;                     // Arithmetic, keeps the sign.
    assign y_sh  = y_snap >>> iter;
    assign z_neg = z_snap[`CORDIC_WORD_W-1];

    always_comb
    begin
        case (slot)
            slot_x:
            begin
                operand_a = x_snap;
                operand_b = y_sh;
                sub       = ~z_neg;                     // x - d*y/2^i.
            end
            slot_y:
            begin
                operand_a = y_snap;
                operand_b = x_sh;
                sub       = z_neg;                      // y + d*x/2^i.
            end
            slot_z:
            begin
                operand_a = z_snap;
                operand_b = atan;
                sub       = ~z_neg;                     // z - d*atan.
            end
            default:
            begin
                operand_a = '0;                         // Unused code.
                operand_b = '0;
                sub       = 1'b0;
            end
        endcase
    end

    assign sum = sub ? (operand_a - operand_b) : (operand_a + operand_b);

    // Result lands at the edge that ends its slot.
    always_ff @(posedge clk)
    begin
        if (slot_en)
        begin
            case (slot)
                slot_x:  x_reg <= sum;
                slot_y:  y_reg <= sum;
                slot_z:  z_reg <= sum;
                default: z_reg <= z_reg;
            endcase
        end
    end

    assign x_out = x_reg;
    assign y_out = y_reg;

endmodule

// File: src/cordic_defs.svh
// ------------------------------
// CORDIC engine constants: word format, iteration count and start-to-ready latency.
// ------------------------------
`ifndef CORDIC_DEFS_SVH
`define CORDIC_DEFS_SVH

`define CORDIC_WORD_W    16                       // Data word width.
`define CORDIC_FRAC_W    14                       // Fraction bits, Q1.14.
`define CORDIC_ITERS     16                       // Iterations per calculation.
`define CORDIC_ITER_BITS 4                        // Width of the iteration index.

// Gain inverse 0.607253 scaled by 2^14.
`define CORDIC_X0        16'sh26DD

// 1 load cycle + 4 cycles per iteration + 1 output cycle.
`define CORDIC_LATENCY   (`CORDIC_ITERS * 4 + 2)

`endif

// File: src/cordic_pkg.sv
// ------------------------------
// CORDIC shared types: data word, iteration index, adder slot and region flag.
// ------------------------------
`include "cordic_defs.svh"

package cordic_pkg;

    // ------------------------------
    // Data and index types
    // ------------------------------
    typedef logic signed [`CORDIC_WORD_W-1:0] cordic_word_t;    // Q1.14 two's complement.
    typedef logic [`CORDIC_ITER_BITS-1:0]     iter_idx_t;       // Iteration 0..15.

    // Owner of the shared adder in one slot cycle.
    typedef enum logic [1:0] {
        slot_x = 2'd0,                                          // X update.
        slot_y = 2'd1,                                          // Y update.
        slot_z = 2'd2                                           // Z update.
    } var_slot_t;

    // Quadrant flag that comes with the folded angle.
    typedef logic [1:0] region_t;

endpackage

// File: src/cordic_quadrant_fix.sv
// ------------------------------
// CORDIC output stage: sine/cosine select, region sign fix, result register.
// ------------------------------
`timescale 1ns/100ps

module cordic_quadrant_fix (
    input  logic                     clk,               // System clock.
    input  logic                     rst_n,             // Async reset, active low.
    input  logic                     capture_cmd,       // Accepted start.
    input  logic                     operation,         // 1 sine, 0 cosine.
    input  cordic_pkg::region_t      shift_region,      // Quadrant of the angle.
    input  logic                     out_en,            // Load the result.
    input  cordic_pkg::cordic_word_t x_out,             // Cosine.
    input  cordic_pkg::cordic_word_t y_out,             // Sine.
    output cordic_pkg::cordic_word_t data_output        // Final result.
);

    import cordic_pkg::*;

    logic         op_q;                                 // Latched operation.
    region_t      region_q;                             // Latched region.
    logic         negate;
    cordic_word_t sel_word;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            op_q     <= 1'b0;
            region_q <= '0;
        end
        else if (capture_cmd)
        begin
            op_q     <= operation;
            region_q <= shift_region;
        end
    end

    // Cosine flips in 01 and 10, sine in 10 and 11.
    assign negate   = op_q ? region_q[1] : (region_q[1] ^ region_q[0]);
    assign sel_word = op_q ? y_out : x_out;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            data_output <= '0;
        end
        else if (out_en)
        begin
            data_output <= negate ? -sel_word : sel_word;   // Held through ready.
        end
    end

endmodule

// File: src/cordic_sequencer.sv
// ------------------------------
// CORDIC control FSM: start/ack handshake, iteration and slot counters.
// ------------------------------
`timescale 1ns/100ps
`include "cordic_defs.svh"

module cordic_sequencer (
    input  logic                   clk,                 // System clock.
    input  logic                   rst_n,               // Async reset, active low.
    input  logic                   beg_cordic,          // Start strobe.
    input  logic                   ack_cordic,          // Result taken.
    output logic                   ready_cordic,        // Result valid level.
    output logic                   load_init,           // Idle, track the angle and arm init.
    output logic                   snap_en,             // Snapshot cycle.
    output logic                   slot_en,             // Shared adder writes.
    output logic                   capture_cmd,         // Accepted start.
    output logic                   out_en,              // Load the result register.
    output cordic_pkg::var_slot_t  slot,                // Adder owner.
    output cordic_pkg::iter_idx_t  iter                 // Iteration index.
);

    import cordic_pkg::*;

    typedef enum logic [2:0] {
        st_idle,                                        // Waiting for a start.
        st_load,                                        // Angle latched, outputs settle.
        st_snap,                                        // Snapshot of X, Y and Z.
        st_slot,                                        // X, Y, Z adder slots.
        st_out,                                         // Result goes to the output stage.
        st_wait_ack                                     // Ready held until ack.
    } state_t;

    state_t state;
    state_t state_nxt;
    logic   start_acc;                                  // Start seen while idle.
    logic   last_slot;                                  // Z slot, end of an iteration.
    logic   last_iter;                                  // Final iteration.

    assign start_acc   = beg_cordic && (state == st_idle);  // Busy engine drops starts.
    assign capture_cmd = start_acc;                     // Same edge as the Z latch.
    assign last_slot   = (slot == slot_z);
    assign last_iter   = (iter == iter_idx_t'(`CORDIC_ITERS - 1));

    // ------------------------------
    // Next state
    // ------------------------------
    always_comb
    begin
        state_nxt = state;                              // Hold by default.
        case (state)
            st_idle:     if (start_acc) state_nxt = st_load;
            st_load:     state_nxt = st_snap;
            st_snap:     state_nxt = st_slot;
            st_slot:
            begin
                if (last_slot)
                begin
                    state_nxt = last_iter ? st_out : st_snap;
                end
            end
            st_out:      state_nxt = st_wait_ack;
            st_wait_ack: if (ack_cordic) state_nxt = st_idle;  // Stalls without ack.
            default:     state_nxt = st_idle;
        endcase
    end

    // State and registered strobes, decoded from the next state.
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state        <= st_idle;
            ready_cordic <= 1'b0;
            load_init    <= 1'b1;                       // Reset lands in idle.
            snap_en      <= 1'b0;
            slot_en      <= 1'b0;
            out_en       <= 1'b0;
        end
        else
        begin
            state        <= state_nxt;
            ready_cordic <= (state_nxt == st_wait_ack);
            load_init    <= (state_nxt == st_idle);
            snap_en      <= (state_nxt == st_snap);
            slot_en      <= (state_nxt == st_slot);
            out_en       <= (state_nxt == st_out);
        end
    end

    // ------------------------------
    // Slot and iteration counters
    // ------------------------------
    // Fixed X, Y, Z order is the grant of the shared adder.
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            slot <= slot_x;
            iter <= '0;
        end
        else if (start_acc)
        begin
            slot <= slot_x;                             // New calculation.
            iter <= '0;
        end
        else if (state == st_slot)
        begin
            case (slot)
                slot_x:  slot <= slot_y;
                slot_y:  slot <= slot_z;
                default:
                begin
                    slot <= slot_x;                     // Wrap for the next iteration.
                    if (!last_iter)
                    begin
                        iter <= iter + 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

// File: src/cordic_top.sv
// ------------------------------
// CORDIC sine/cosine engine, rotation mode, one time-shared adder.
// ------------------------------
`timescale 1ns/100ps

module cordic_top (
    input  logic                     clk,               // System clock.
    input  logic                     rst_n,             // Async reset, active low.
    input  logic                     beg_cordic,        // Start strobe.
    input  logic                     ack_cordic,        // Result taken.
    input  logic                     operation,         // 1 sine, 0 cosine.
    input  cordic_pkg::region_t      shift_region,      // Quadrant flag.
    input  cordic_pkg::cordic_word_t data_in,           // Angle within +-pi/2.
    output logic                     ready_cordic,      // Result valid.
    output cordic_pkg::cordic_word_t data_output        // Sine or cosine.
);

    import cordic_pkg::*;

    logic         load_init;
    logic         snap_en;
    logic         slot_en;
    logic         capture_cmd;
    logic         out_en;
    var_slot_t    slot;
    iter_idx_t    iter;
    cordic_word_t atan;
    cordic_word_t x_out;
    cordic_word_t y_out;

    // ------------------------------
    // Control
    // ------------------------------
    cordic_sequencer u_sequencer (
        .clk          (clk),
        .rst_n        (rst_n),
        .beg_cordic   (beg_cordic),
        .ack_cordic   (ack_cordic),
        .ready_cordic (ready_cordic),
        .load_init    (load_init),
        .snap_en      (snap_en),
        .slot_en      (slot_en),
        .capture_cmd  (capture_cmd),
        .out_en       (out_en),
        .slot         (slot),
        .iter         (iter)
    );

    // ------------------------------
    // Datapath and table
    // ------------------------------
    cordic_atan_rom u_atan_rom (
        .iter (iter),
        .atan (atan)
    );

    cordic_datapath u_datapath (
        .clk       (clk),
        .rst_n     (rst_n),
        .data_in   (data_in),
        .load_init (load_init),
        .snap_en   (snap_en),
        .slot_en   (slot_en),
        .slot      (slot),
        .iter      (iter),
        .atan      (atan),
        .x_out     (x_out),
        .y_out     (y_out)
    );

    cordic_quadrant_fix u_quadrant_fix (
        .clk          (clk),
        .rst_n        (rst_n),
        .capture_cmd  (capture_cmd),
        .operation    (operation),
        .shift_region (shift_region),
        .out_en       (out_en),
        .x_out        (x_out),
        .y_out        (y_out),
        .data_output  (data_output)
    );

endmodule
